// ==== cache_pkg.sv ====
package cache_pkg;

    // byte address of a request
    parameter int DEFAULT_ADDRESS_WIDTH = 12;

    // one word per cache line
    parameter int DEFAULT_DATA_WIDTH = 32;

    // 3 index bits, so 8 sets
    parameter int DEFAULT_SET_WIDTH = 3;

    // words are always 4 bytes wide
    parameter int OFFSET_WIDTH = 2;

    // cycles from a memory request to its done pulse, at least 2
    parameter int DEFAULT_MEM_LATENCY = 4;

endpackage

// ==== cache_req_in.sv ====
module cache_req_in #(
    parameter int ADDRESS_WIDTH = cache_pkg::DEFAULT_ADDRESS_WIDTH,
    parameter int DATA_WIDTH    = cache_pkg::DEFAULT_DATA_WIDTH
) (
    input  logic                     clk_i,
    input  logic                     reset_i,
    // requester side
    input  logic                     req_valid_i,
    output logic                     req_ready_o,
    input  logic                     req_wen_i,
    input  logic [ADDRESS_WIDTH-1:0] req_addr_i,
    input  logic [DATA_WIDTH-1:0]    req_wdata_i,
    // controller side
    output logic                     op_valid_o,
    input  logic                     op_ready_i,
    output logic                     op_wen_o,
    output logic [ADDRESS_WIDTH-1:0] op_addr_o,
    output logic [DATA_WIDTH-1:0]    op_wdata_o
);

    logic full_q;
    logic accept;

    // slot can take a new request if empty or emptied this cycle
    assign req_ready_o = !full_q || op_ready_i;
    assign accept      = req_valid_i && req_ready_o;

    // a full slot is offered straight to the controller
    assign op_valid_o = full_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            full_q <= 1'b0;
        end else if (accept) begin
            // refill wins over drain in the same cycle
            full_q <= 1'b1;
        end else if (full_q && op_ready_i) begin
            full_q <= 1'b0;
        end
    end

    // request fields, loaded only on a transfer
    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_wen_o   <= req_wen_i;
            op_addr_o  <= req_addr_i;
            op_wdata_o <= req_wdata_i;
        end
    end

endmodule

// ==== direct_cache.sv ====
module direct_cache #(
    parameter int ADDRESS_WIDTH = cache_pkg::DEFAULT_ADDRESS_WIDTH,
    parameter int DATA_WIDTH    = cache_pkg::DEFAULT_DATA_WIDTH,
    parameter int SET_WIDTH     = cache_pkg::DEFAULT_SET_WIDTH
) (
    input  logic                     clk_i,
    input  logic                     reset_i,
    // operation from the input slot
    input  logic                     op_valid_i,
    output logic                     op_ready_o,
    input  logic                     op_wen_i,
    input  logic [ADDRESS_WIDTH-1:0] op_addr_i,
    input  logic [DATA_WIDTH-1:0]    op_wdata_i,
    // backing memory
    output logic                     mem_req_o,
    output logic                     mem_wen_o,
    output logic [ADDRESS_WIDTH-1:0] mem_addr_o,
    output logic [DATA_WIDTH-1:0]    mem_wdata_o,
    input  logic                     mem_done_i,
    input  logic [DATA_WIDTH-1:0]    mem_rdata_i,
    // response FIFO
    output logic                     rsp_push_o,
    output logic                     rsp_hit_o,
    output logic [DATA_WIDTH-1:0]    rsp_data_o,
    input  logic                     rsp_space_i
);

    import cache_pkg::*;

    localparam int TAG_WIDTH = ADDRESS_WIDTH - SET_WIDTH - OFFSET_WIDTH;
    localparam int NUM_SETS  = 2 ** SET_WIDTH;

    localparam logic [1:0] ST_IDLE      = 2'd0;
    localparam logic [1:0] ST_WRITEBACK = 2'd1;
    localparam logic [1:0] ST_REFILL    = 2'd2;

    // line storage with one word per set
    logic [TAG_WIDTH-1:0]  tag_mem  [NUM_SETS];
    logic [DATA_WIDTH-1:0] data_mem [NUM_SETS];
    logic [NUM_SETS-1:0]   valid_q;
    logic [NUM_SETS-1:0]   dirty_q;

    logic [1:0]               state_q;
    logic [1:0]               state_d;
    logic                     hit_q;
    logic                     wen_q;
    logic [ADDRESS_WIDTH-1:0] addr_q;
    logic [DATA_WIDTH-1:0]    wdata_q;

    logic                     mem_req_q;
    logic                     mem_wen_q;
    logic [ADDRESS_WIDTH-1:0] mem_addr_q;
    logic [DATA_WIDTH-1:0]    mem_wdata_q;

    logic [SET_WIDTH-1:0] op_set;
    logic [TAG_WIDTH-1:0] op_tag;
    logic [SET_WIDTH-1:0] q_set;
    logic [TAG_WIDTH-1:0] q_tag;
    logic                 op_hit;
    logic                 victim_dirty;
    logic                 accept;
    logic                 issue_wb;
    logic                 issue_rd;
    logic                 chain_rd;

    logic                  install_en;
    logic [SET_WIDTH-1:0]  inst_set;
    logic [TAG_WIDTH-1:0]  inst_tag;
    logic [DATA_WIDTH-1:0] inst_data;
    logic                  inst_dirty;
    logic                  push_en;
    logic [DATA_WIDTH-1:0] push_data;

    // set sits above the byte offset and the tag takes the rest
    assign op_set = op_addr_i[SET_WIDTH+OFFSET_WIDTH-1:OFFSET_WIDTH];
    assign op_tag = op_addr_i[ADDRESS_WIDTH-1:SET_WIDTH+OFFSET_WIDTH];
    assign q_set  = addr_q[SET_WIDTH+OFFSET_WIDTH-1:OFFSET_WIDTH];
    assign q_tag  = addr_q[ADDRESS_WIDTH-1:SET_WIDTH+OFFSET_WIDTH];

    assign op_hit       = valid_q[op_set] && (tag_mem[op_set] == op_tag);
    assign victim_dirty = valid_q[op_set] && dirty_q[op_set];

    // no new op while a response is still on its way into the FIFO
    assign op_ready_o = (state_q == ST_IDLE) && rsp_space_i && !rsp_push_o;
    assign accept     = op_valid_i && op_ready_o;

    // hit flag as registered at acceptance, held until the push
    assign rsp_hit_o = hit_q;

    // misses that need the memory
    assign issue_wb = accept && !op_hit && victim_dirty;
    assign issue_rd = accept && !op_hit && !victim_dirty && !op_wen_i;

    // refill read goes out in the cycle the writeback completes
    assign chain_rd = (state_q == ST_WRITEBACK) && mem_done_i && !wen_q;

    assign mem_req_o   = mem_req_q || chain_rd;
    assign mem_wen_o   = mem_wen_q && !chain_rd;
    assign mem_addr_o  = chain_rd ? addr_q : mem_addr_q;
    assign mem_wdata_o = mem_wdata_q;

    // line install and response for every path
    always_comb begin
        install_en = 1'b0;
        inst_set   = op_set;
        inst_tag   = op_tag;
        inst_data  = op_wdata_i;
        inst_dirty = 1'b1;
        push_en    = 1'b0;
        push_data  = op_wdata_i;
        state_d    = state_q;
        case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    if (op_hit && !op_wen_i) begin
                        // read hit
                        push_en   = 1'b1;
                        push_data = data_mem[op_set];
                    end else if (op_wen_i && (op_hit || !victim_dirty)) begin
                        // write hit, or write allocate over a clean line
                        install_en = 1'b1;
                        push_en    = 1'b1;
                    end else if (issue_wb) begin
                        state_d = ST_WRITEBACK;
                    end else begin
                        state_d = ST_REFILL;
                    end
                end
            end
            ST_WRITEBACK: begin
                inst_set  = q_set;
                inst_tag  = q_tag;
                inst_data = wdata_q;
                push_data = wdata_q;
                if (mem_done_i) begin
                    if (wen_q) begin
                        // victim is out so the write allocates now
                        install_en = 1'b1;
                        push_en    = 1'b1;
                        state_d    = ST_IDLE;
                    end else begin
                        state_d = ST_REFILL;
                    end
                end
            end
            ST_REFILL: begin
                inst_set   = q_set;
                inst_tag   = q_tag;
                inst_data  = mem_rdata_i;
                inst_dirty = 1'b0;
                push_data  = mem_rdata_i;
                if (mem_done_i) begin
                    install_en = 1'b1;
                    push_en    = 1'b1;
                    state_d    = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    // control state
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q    <= ST_IDLE;
            valid_q    <= '0;
            dirty_q    <= '0;
            hit_q      <= 1'b0;
            rsp_push_o <= 1'b0;
            mem_req_q  <= 1'b0;
        end else begin
            state_q    <= state_d;
            rsp_push_o <= push_en;
            mem_req_q  <= issue_wb || issue_rd;
            if (accept) begin
                hit_q <= op_hit;
            end
            if (install_en) begin
                valid_q[inst_set] <= 1'b1;
                dirty_q[inst_set] <= inst_dirty;
            end
        end
    end

    // arrays and payload
    always_ff @(posedge clk_i) begin
        if (accept) begin
            wen_q   <= op_wen_i;
            addr_q  <= op_addr_i;
            wdata_q <= op_wdata_i;
        end
        if (install_en) begin
            tag_mem[inst_set]  <= inst_tag;
            data_mem[inst_set] <= inst_data;
        end
        if (push_en) begin
            rsp_data_o <= push_data;
        end
        if (issue_wb) begin
            // victim address from stored tag, set and zero offset
            mem_wen_q   <= 1'b1;
            mem_addr_q  <= {tag_mem[op_set], op_set, {OFFSET_WIDTH{1'b0}}};
            mem_wdata_q <= data_mem[op_set];
        end else if (issue_rd) begin
            mem_wen_q  <= 1'b0;
            mem_addr_q <= op_addr_i;
        end
    end

endmodule

// ==== data_memory.sv ====
module data_memory #(
    parameter int ADDRESS_WIDTH = cache_pkg::DEFAULT_ADDRESS_WIDTH,
    parameter int DATA_WIDTH    = cache_pkg::DEFAULT_DATA_WIDTH,
    parameter int MEM_LATENCY   = cache_pkg::DEFAULT_MEM_LATENCY
) (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic                     mem_req_i,
    input  logic                     mem_wen_i,
    input  logic [ADDRESS_WIDTH-1:0] mem_addr_i,
    input  logic [DATA_WIDTH-1:0]    mem_wdata_i,
    output logic                     mem_done_o,
    output logic [DATA_WIDTH-1:0]    mem_rdata_o
);

    import cache_pkg::*;

    localparam int INDEX_WIDTH = ADDRESS_WIDTH - OFFSET_WIDTH;
    localparam int NUM_WORDS   = 2 ** INDEX_WIDTH;
    localparam int CNT_WIDTH   = $clog2(MEM_LATENCY + 1);

    logic [DATA_WIDTH-1:0]  mem_q [NUM_WORDS];
    logic [CNT_WIDTH-1:0]   cnt_q;
    logic                   wen_q;
    logic [INDEX_WIDTH-1:0] index_q;
    logic [DATA_WIDTH-1:0]  wdata_q;
    logic                   fire;

    // memory powers up cleared
    initial begin
        for (int i = 0; i < NUM_WORDS; i++) begin
            mem_q[i] = '0;
        end
    end

    // last step of the countdown does the access
    assign fire = (cnt_q == CNT_WIDTH'(1));

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cnt_q      <= '0;
            mem_done_o <= 1'b0;
        end else begin
            mem_done_o <= fire;
            if (mem_req_i) begin
                cnt_q <= CNT_WIDTH'(MEM_LATENCY - 1);
            end else if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // word array and captured request
    always_ff @(posedge clk_i) begin
        if (mem_req_i) begin
            wen_q   <= mem_wen_i;
            index_q <= mem_addr_i[ADDRESS_WIDTH-1:OFFSET_WIDTH];
            wdata_q <= mem_wdata_i;
        end
        if (fire) begin
            if (wen_q) begin
                mem_q[index_q] <= wdata_q;
            end else begin
                mem_rdata_o <= mem_q[index_q];
            end
        end
    end

endmodule

// ==== cache_resp_out.sv ====
module cache_resp_out #(
    parameter int DATA_WIDTH = cache_pkg::DEFAULT_DATA_WIDTH
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    // from the controller
    input  logic                  rsp_push_i,
    input  logic                  rsp_hit_i,
    input  logic [DATA_WIDTH-1:0] rsp_data_i,
    output logic                  rsp_space_o,
    // to the requester
    output logic                  resp_valid_o,
    input  logic                  resp_ready_i,
    output logic                  resp_hit_o,
    output logic [DATA_WIDTH-1:0] resp_rdata_o
);

    logic [DATA_WIDTH-1:0] data_q [2];
    logic [1:0]            hit_q;
    logic                  wr_ptr_q;
    logic                  rd_ptr_q;
    logic [1:0]            count_q;
    logic                  pop;

    assign resp_valid_o = (count_q != 2'd0);
    assign pop          = resp_valid_o && resp_ready_i;

    // only depends on stored count, never on resp_ready_i
    assign rsp_space_o = (count_q != 2'd2);

    // head entry
    assign resp_hit_o   = hit_q[rd_ptr_q];
    assign resp_rdata_o = data_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else begin
            if (rsp_push_i) begin
                wr_ptr_q <= !wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= !rd_ptr_q;
            end
            // push and pop together leave the count alone
            case ({rsp_push_i, pop})
                2'b10:   count_q <= count_q + 2'd1;
                2'b01:   count_q <= count_q - 2'd1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (rsp_push_i) begin
            data_q[wr_ptr_q] <= rsp_data_i;
            hit_q[wr_ptr_q]  <= rsp_hit_i;
        end
    end

endmodule

// ==== cache_system.sv ====
module cache_system #(
    parameter int ADDRESS_WIDTH = cache_pkg::DEFAULT_ADDRESS_WIDTH,
    parameter int DATA_WIDTH    = cache_pkg::DEFAULT_DATA_WIDTH,
    parameter int SET_WIDTH     = cache_pkg::DEFAULT_SET_WIDTH,
    parameter int MEM_LATENCY   = cache_pkg::DEFAULT_MEM_LATENCY
) (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic                     req_valid_i,
    output logic                     req_ready_o,
    input  logic                     req_wen_i,
    input  logic [ADDRESS_WIDTH-1:0] req_addr_i,
    input  logic [DATA_WIDTH-1:0]    req_wdata_i,
    output logic                     resp_valid_o,
    input  logic                     resp_ready_i,
    output logic                     resp_hit_o,
    output logic [DATA_WIDTH-1:0]    resp_rdata_o
);

    // input slot to controller
    logic                     op_valid;
    logic                     op_ready;
    logic                     op_wen;
    logic [ADDRESS_WIDTH-1:0] op_addr;
    logic [DATA_WIDTH-1:0]    op_wdata;

    // controller to memory
    logic                     mem_req;
    logic                     mem_wen;
    logic [ADDRESS_WIDTH-1:0] mem_addr;
    logic [DATA_WIDTH-1:0]    mem_wdata;
    logic                     mem_done;
    logic [DATA_WIDTH-1:0]    mem_rdata;

    // controller to response FIFO
    logic                  rsp_push;
    logic                  rsp_hit;
    logic [DATA_WIDTH-1:0] rsp_data;
    logic                  rsp_space;

    cache_req_in #(
        .ADDRESS_WIDTH (ADDRESS_WIDTH),
        .DATA_WIDTH    (DATA_WIDTH)
    ) i_req_in (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_wen_i   (req_wen_i),
        .req_addr_i  (req_addr_i),
        .req_wdata_i (req_wdata_i),
        .op_valid_o  (op_valid),
        .op_ready_i  (op_ready),
        .op_wen_o    (op_wen),
        .op_addr_o   (op_addr),
        .op_wdata_o  (op_wdata)
    );

    direct_cache #(
        .ADDRESS_WIDTH (ADDRESS_WIDTH),
        .DATA_WIDTH    (DATA_WIDTH),
        .SET_WIDTH     (SET_WIDTH)
    ) i_cache (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .op_valid_i  (op_valid),
        .op_ready_o  (op_ready),
        .op_wen_i    (op_wen),
        .op_addr_i   (op_addr),
        .op_wdata_i  (op_wdata),
        .mem_req_o   (mem_req),
        .mem_wen_o   (mem_wen),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_done_i  (mem_done),
        .mem_rdata_i (mem_rdata),
        .rsp_push_o  (rsp_push),
        .rsp_hit_o   (rsp_hit),
        .rsp_data_o  (rsp_data),
        .rsp_space_i (rsp_space)
    );

    data_memory #(
        .ADDRESS_WIDTH (ADDRESS_WIDTH),
        .DATA_WIDTH    (DATA_WIDTH),
        .MEM_LATENCY   (MEM_LATENCY)
    ) i_memory (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .mem_req_i   (mem_req),
        .mem_wen_i   (mem_wen),
        .mem_addr_i  (mem_addr),
        .mem_wdata_i (mem_wdata),
        .mem_done_o  (mem_done),
        .mem_rdata_o (mem_rdata)
    );

    cache_resp_out #(
        .DATA_WIDTH (DATA_WIDTH)
    ) i_resp_out (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .rsp_push_i   (rsp_push),
        .rsp_hit_i    (rsp_hit),
        .rsp_data_i   (rsp_data),
        .rsp_space_o  (rsp_space),
        .resp_valid_o (resp_valid_o),
        .resp_ready_i (resp_ready_i),
        .resp_hit_o   (resp_hit_o),
        .resp_rdata_o (resp_rdata_o)
    );

endmodule

// ==== tb_cache_system.sv ====
module tb_cache_system;

    timeunit 1ns;
    timeprecision 1ps;

    import cache_pkg::*;

    localparam int AW         = DEFAULT_ADDRESS_WIDTH;
    localparam int DW         = DEFAULT_DATA_WIDTH;
    localparam int WAIT_LIMIT = 300;
    localparam logic [31:0] RANDOM_SEED = 32'hfd3fff8e;

    logic          clk_i;
    logic          reset_i;
    logic          req_valid_i;
    logic          req_ready_o;
    logic          req_wen_i;
    logic [AW-1:0] req_addr_i;
    logic [DW-1:0] req_wdata_i;
    logic          resp_valid_o;
    logic          resp_ready_i;
    logic          resp_hit_o;
    logic [DW-1:0] resp_rdata_o;

    // requests and expected responses from the golden file
    logic          req_wen_list    [$];
    logic [AW-1:0] req_addr_list   [$];
    logic [DW-1:0] req_wdata_list  [$];
    logic [DW-1:0] gold_rdata_list [$];
    logic          gold_hit_list   [$];

    // responses still owed with the oldest first
    logic [DW-1:0] exp_rdata_q [$];
    logic          exp_hit_q   [$];

    int num_requests  = 0;
    int checked_count = 0;

    cache_system i_dut (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .req_wen_i    (req_wen_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .resp_valid_o (resp_valid_o),
        .resp_ready_i (resp_ready_i),
        .resp_hit_o   (resp_hit_o),
        .resp_rdata_o (resp_rdata_o)
    );

    initial clk_i = 1'b0;
    always #5 clk_i = ~clk_i;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR: %s is 0x%h, expected 0x%h", name, actual, expected));
        end
    endtask

    // one request per line and # marks a note line
    task automatic load_golden();
        int          fd;
        int          fields;
        int          line_no;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_addr;
        logic [31:0] f_wdata;
        logic [31:0] f_rdata;
        logic [31:0] f_hit;
        line_no = 0;
        fd = $fopen("cache_golden.txt", "r");
        if (fd == 0) begin
            abort_run("could not open cache_golden.txt for reading");
        end else begin
            while ($fgets(line, fd) != 0) begin
                line_no++;
                if (line.len() > 1 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%h %h %h %h %h",
                                     f_op, f_addr, f_wdata, f_rdata, f_hit);
                    if (fields != 5) begin
                        abort_run($sformatf("line %0d of cache_golden.txt is malformed",
                                            line_no));
                    end else begin
                        req_wen_list.push_back(f_op[0]);
                        req_addr_list.push_back(f_addr[AW-1:0]);
                        req_wdata_list.push_back(f_wdata[DW-1:0]);
                        gold_rdata_list.push_back(f_rdata[DW-1:0]);
                        gold_hit_list.push_back(f_hit[0]);
                    end
                end
            end
            $fclose(fd);
            num_requests = req_addr_list.size();
        end
    endtask

    // requests in file order with a short idle gap now and then
    task automatic send_requests();
        int waited;
        for (int i = 0; i < num_requests; i++) begin
            req_valid_i <= 1'b1;
            req_wen_i   <= req_wen_list[i];
            req_addr_i  <= req_addr_list[i];
            req_wdata_i <= req_wdata_list[i];
            waited = 0;
            @(negedge clk_i);
            while (!req_ready_o) begin
                if (waited == WAIT_LIMIT) begin
                    abort_run($sformatf("request %0d was not accepted in %0d cycles",
                                        i, WAIT_LIMIT));
                end else begin
                    waited++;
                    @(negedge clk_i);
                end
            end
            // ready is high so the transfer is on the coming edge
            exp_rdata_q.push_back(gold_rdata_list[i]);
            exp_hit_q.push_back(gold_hit_list[i]);
            @(posedge clk_i);
            if (i % 3 == 2) begin
                req_valid_i <= 1'b0;
                @(posedge clk_i);
            end
        end
        req_valid_i <= 1'b0;
    endtask

    task automatic wait_for_responses();
        int waited;
        waited = 0;
        while (checked_count < num_requests) begin
            if (waited == WAIT_LIMIT) begin
                abort_run($sformatf("only %0d of %0d responses arrived in time",
                                    checked_count, num_requests));
            end else begin
                waited++;
                @(posedge clk_i);
            end
        end
    endtask

    // random back-pressure with ready about two cycles in three and long stalls
    initial begin
        int cycle;
        void'($urandom(RANDOM_SEED));
        cycle = 0;
        resp_ready_i <= 1'b0;
        forever begin
            @(posedge clk_i);
            cycle++;
            resp_ready_i <= (cycle % 48 >= 12) && (($urandom % 3) != 0);
        end
    end

    // response checker sampled mid-cycle where outputs are settled
    initial begin
        forever begin
            @(negedge clk_i);
            if (!reset_i && resp_valid_o && resp_ready_i) begin
                if (exp_rdata_q.size() == 0) begin
                    abort_run("a response arrived with no request outstanding");
                end else begin
                    check_value($sformatf("resp_hit_o[%0d]", checked_count),
                                32'(resp_hit_o), 32'(exp_hit_q.pop_front()));
                    check_value($sformatf("resp_rdata_o[%0d]", checked_count),
                                32'(resp_rdata_o), 32'(exp_rdata_q.pop_front()));
                    checked_count++;
                end
            end
        end
    end

    initial begin
        reset_i     <= 1'b1;
        req_valid_i <= 1'b0;
        req_wen_i   <= 1'b0;
        req_addr_i  <= '0;
        req_wdata_i <= '0;
        load_golden();
        repeat (16) @(posedge clk_i);
        reset_i <= 1'b0;
        // idle outputs right after reset
        @(negedge clk_i);
        check_value("req_ready_o", 32'(req_ready_o), 32'd1);
        check_value("resp_valid_o", 32'(resp_valid_o), 32'd0);
        @(posedge clk_i);
        send_requests();
        wait_for_responses();
        // quiet window where a stray extra response would show
        repeat (4 * DEFAULT_MEM_LATENCY) @(negedge clk_i);
        if (num_requests > 0 && checked_count == num_requests && exp_rdata_q.size() == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            abort_run($sformatf("%0d of %0d requests were answered and checked",
                                checked_count, num_requests));
        end
    end

endmodule

// ==== cache_golden.txt ====
# columns: op (1 = write), byte address, write data, expected data, expected hit; all hex
# expected values follow direct-mapped write-back rules with memory starting at zero
0 000 00000000 00000000 0
0 000 00000000 00000000 1
0 104 00000000 00000000 0
0 104 00000000 00000000 1
1 008 deadbeef deadbeef 0
0 008 00000000 deadbeef 1
1 008 12345678 12345678 1
0 008 00000000 12345678 1
1 028 a5a5a5a5 a5a5a5a5 0
0 008 00000000 12345678 0
0 028 00000000 a5a5a5a5 0
0 028 00000000 a5a5a5a5 1
0 020 00000000 00000000 0
1 00c 0badf00d 0badf00d 0
1 06c cafef00d cafef00d 0
0 00c 00000000 0badf00d 0
0 06c 00000000 cafef00d 0
0 00c 00000000 0badf00d 0
0 00c 00000000 0badf00d 1
1 010 11111111 11111111 0
1 014 22222222 22222222 0
1 018 33333333 33333333 0
1 01c 44444444 44444444 0
0 010 00000000 11111111 1
0 014 00000000 22222222 1
0 018 00000000 33333333 1
0 01c 00000000 44444444 1
0 030 00000000 00000000 0
0 010 00000000 11111111 0
1 034 55555555 55555555 0
0 014 00000000 22222222 0
0 034 00000000 55555555 0
1 034 66666666 66666666 1
0 034 00000000 66666666 1
0 fe0 00000000 00000000 0
0 104 00000000 00000000 1
0 008 00000000 12345678 0
0 01c 00000000 44444444 1
0 01e 00000000 44444444 1

// ==== cache_system.f ====
cache_pkg.sv
cache_req_in.sv
direct_cache.sv
data_memory.sv
cache_resp_out.sv
cache_system.sv
tb_cache_system.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary -Wno-fatal --top-module tb_cache_system \
    -f cache_system.f -o sim_cache_system; then
    echo "compile failed"
    exit 1
fi

output=$(./obj_dir/sim_cache_system 2>&1)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q '^\*\*\* PASSED \*\*\*$'; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
